//--- Bender.yml
package:
  name: exe_stage

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/exe_uop_pkg.sv
      - design/exe_pipe_pkg.sv
      - design/exe_bypass_if.sv
      - design/exe_bypass.sv
      - design/exe_alu.sv
      - design/exe_mul.sv
      - design/exe_lsu.sv
      - design/exe_stage.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/exe_stage_tb.sv

//--- design/exe_alu.sv
`timescale 1ns/1ns
`default_nettype none
`include "exe_config.svh"

module exe_alu
    import exe_uop_pkg::*;
(
    input  uop_t                 uop,
    input  logic [`EXE_XLEN-1:0] op0,
    input  logic [`EXE_XLEN-1:0] op1,
    output logic [`EXE_XLEN-1:0] result
);

    logic [`EXE_XLEN-1:0] b;
    logic [4:0]           shamt;
    logic                 lt_s;
    logic                 lt_u;

    assign b     = uop.use_imm ? uop.imm : op1;
    assign shamt = b[4:0];
    assign lt_s  = $signed(op0) < $signed(b);
    assign lt_u  = op0 < b;

    always_comb begin
        case (uop.alu_op)
            ALU_ADD:  result = op0 + b;
            ALU_SUB:  result = op0 - b;
            ALU_SLT:  result = {{(`EXE_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result = {{(`EXE_XLEN-1){1'b0}}, lt_u};
            ALU_AND:  result = op0 & b;
            ALU_OR:   result = op0 | b;
            ALU_XOR:  result = op0 ^ b;
            ALU_NOR:  result = ~(op0 | b);
            ALU_SLL:  result = op0 << shamt;
            ALU_SRL:  result = op0 >> shamt;
            ALU_SRA:  result = $unsigned($signed(op0) >>> shamt);
            ALU_LUI:  result = uop.imm;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/exe_bypass.sv
`timescale 1ns/1ns
`default_nettype none
`include "exe_config.svh"

module exe_bypass
    import exe_uop_pkg::*;
    import exe_pipe_pkg::*;
(
    input  uop_t                 lane0_uop,
    input  uop_t                 lane1_uop,
    input  logic [`EXE_XLEN-1:0] lane0_src0,
    input  logic [`EXE_XLEN-1:0] lane0_src1,
    input  logic [`EXE_XLEN-1:0] lane1_src0,
    input  logic [`EXE_XLEN-1:0] lane1_src1,
    input  logic                 lane0_en,
    input  logic                 lane1_en,
    exe_bypass_if.bypass         bus,
    output logic [`EXE_XLEN-1:0] lane0_op0,
    output logic [`EXE_XLEN-1:0] lane0_op1,
    output logic [`EXE_XLEN-1:0] lane1_op0,
    output logic [`EXE_XLEN-1:0] lane1_op1,
    output logic                 hazard
);

    // index 0 is the newest result
    lane_result_t [3:0] cand;

    function automatic logic [`EXE_XLEN-1:0] pick(
        input logic [`EXE_RADDR_W-1:0] rs,
        input logic [`EXE_XLEN-1:0]    rf_val,
        input lane_result_t [3:0]      c
    );
        logic [`EXE_XLEN-1:0] val;
        val = rf_val;
        // oldest first so the newest match wins
        for (int i = 3; i >= 0; i--) begin
            if (c[i].valid && c[i].rd == rs && rs != '0) begin
                val = c[i].data;
            end
        end
        return val;
    endfunction

    assign cand = {bus.s2_l0, bus.s2_l1, bus.s1_l0, bus.s1_l1};

    assign lane0_op0 = pick(lane0_uop.rj, lane0_src0, cand);
    assign lane0_op1 = pick(lane0_uop.rk, lane0_src1, cand);
    assign lane1_op0 = pick(lane1_uop.rj, lane1_src0, cand);
    assign lane1_op1 = pick(lane1_uop.rk, lane1_src1, cand);

    // r0 never reaches pend_rd, the pipe filters it
    assign hazard = bus.pend_valid && (
        (lane0_en && (lane0_uop.rj == bus.pend_rd || lane0_uop.rk == bus.pend_rd)) ||
        (lane1_en && (lane1_uop.rj == bus.pend_rd || lane1_uop.rk == bus.pend_rd)));

    hazard_not_r0: assert property (@(posedge bus.clk) hazard |-> bus.pend_rd != '0)
        else $error("load-use stall raised for r0");

endmodule

`default_nettype wire

//--- design/exe_bypass_if.sv
`timescale 1ns/1ns
`default_nettype none
`include "exe_config.svh"

interface exe_bypass_if
    import exe_pipe_pkg::*;
(
    input logic clk
);

    // finished results still in flight
    lane_result_t s1_l0;
    lane_result_t s1_l1;
    lane_result_t s2_l0;
    lane_result_t s2_l1;

    // multiply or load in E1, result not ready yet
    logic                    pend_valid;
    logic [`EXE_RADDR_W-1:0] pend_rd;

    modport pipe (
        input  clk,
        output s1_l0, s1_l1, s2_l0, s2_l1, pend_valid, pend_rd
    );

    modport bypass (
        input clk, s1_l0, s1_l1, s2_l0, s2_l1, pend_valid, pend_rd
    );

endinterface

`default_nettype wire

//--- design/exe_config.svh
`ifndef EXE_CONFIG_SVH
`define EXE_CONFIG_SVH

// datapath and address width
`define EXE_XLEN 32

// architectural register file
`define EXE_RADDR_W 5
`define EXE_NUM_REGS 32

// one strobe bit per byte of a data word
`define EXE_STRB_W 4

`endif

//--- design/exe_lsu.sv
`timescale 1ns/1ns
`default_nettype none
`include "exe_config.svh"

module exe_lsu
    import exe_uop_pkg::*;
    import exe_pipe_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    en,
    input  uop_t                    uop,
    input  logic [`EXE_XLEN-1:0]    base,
    input  logic [`EXE_XLEN-1:0]    store_data,
    output logic                    busy,
    output logic                    done,
    output logic [`EXE_RADDR_W-1:0] rd,
    output logic [`EXE_XLEN-1:0]    load_data,
    output logic                    mem_req_valid,
    input  logic                    mem_req_ready,
    output logic                    mem_req_write,
    output logic [`EXE_XLEN-1:0]    mem_req_addr,
    output logic [`EXE_STRB_W-1:0]  mem_req_strb,
    output logic [`EXE_XLEN-1:0]    mem_req_wdata,
    input  logic                    mem_rsp_valid,
    input  logic [`EXE_XLEN-1:0]    mem_rsp_rdata
);

    mem_entry_t           entry;
    mem_entry_t           entry_next;
    logic                 sent;
    logic [`EXE_XLEN-1:0] addr;
    logic [`EXE_XLEN-1:0] shifted;

    assign addr = base + uop.imm;

    always_comb begin
        entry_next.valid    = 1'b1;
        entry_next.write    = uop.mem_write;
        entry_next.sign_ext = uop.sign_ext;
        entry_next.width    = uop.mem_width;
        // stores have no destination
        entry_next.rd       = uop.mem_write ? '0 : uop.rd;
        entry_next.addr     = addr;
        case (uop.mem_width)
            MEM_B: begin
                entry_next.strb  = `EXE_STRB_W'(1) << addr[1:0];
                entry_next.wdata = {(`EXE_XLEN/8){store_data[7:0]}};
            end
            MEM_H: begin
                entry_next.strb  = `EXE_STRB_W'(3) << {addr[1], 1'b0};
                entry_next.wdata = {(`EXE_XLEN/16){store_data[15:0]}};
            end
            default: begin
                entry_next.strb  = '1;
                entry_next.wdata = store_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            entry.valid <= 1'b0;
            sent        <= 1'b0;
        end else if (en) begin
            entry <= entry_next;
            sent  <= 1'b0;
        end else begin
            if (mem_req_valid && mem_req_ready) begin
                sent <= 1'b1;
            end
            if (mem_rsp_valid) begin
                entry.valid <= 1'b0;
            end
        end
    end

    assign mem_req_valid = entry.valid && !sent;
    assign mem_req_write = entry.write;
    assign mem_req_addr  = entry.addr;
    assign mem_req_strb  = entry.strb;
    assign mem_req_wdata = entry.wdata;

    assign busy = entry.valid && !mem_rsp_valid;
    assign done = entry.valid && mem_rsp_valid && entry.rd != '0;
    assign rd   = entry.rd;

    // addressed byte or half down to bit 0
    assign shifted = mem_rsp_rdata >> {entry.addr[1:0], 3'b000};

    always_comb begin
        case (entry.width)
            MEM_B:   load_data = {{(`EXE_XLEN-8){entry.sign_ext && shifted[7]}}, shifted[7:0]};
            MEM_H:   load_data = {{(`EXE_XLEN-16){entry.sign_ext && shifted[15]}},
                                  shifted[15:0]};
            default: load_data = shifted;
        endcase
    end

    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid &&
            $stable({mem_req_write, mem_req_addr, mem_req_strb, mem_req_wdata}))
        else $error("memory request changed while waiting for ready");

    rsp_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp_valid |-> entry.valid && sent)
        else $error("memory response without outstanding request");

endmodule

`default_nettype wire

//--- design/exe_mul.sv
`timescale 1ns/1ns
`default_nettype none
`include "exe_config.svh"

module exe_mul
    import exe_uop_pkg::*;
    import exe_pipe_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    en,
    input  logic                    hold,
    input  uop_t                    uop,
    input  logic [`EXE_XLEN-1:0]    op0,
    input  logic [`EXE_XLEN-1:0]    op1,
    output logic                    done,
    output logic [`EXE_RADDR_W-1:0] rd,
    output logic [`EXE_XLEN-1:0]    product
);

    localparam int HALF = `EXE_XLEN / 2;

    mul_part_t                part;
    mul_part_t                part_next;
    logic [2*`EXE_XLEN-1:0]   full;

    always_comb begin
        part_next.pp_hh = op0[`EXE_XLEN-1:HALF] * op1[`EXE_XLEN-1:HALF];
        part_next.pp_hl = op0[`EXE_XLEN-1:HALF] * op1[HALF-1:0];
        part_next.pp_lh = op0[HALF-1:0] * op1[`EXE_XLEN-1:HALF];
        part_next.pp_ll = op0[HALF-1:0] * op1[HALF-1:0];
        // signed high word: take off each operand whose partner is negative
        part_next.adj = '0;
        if (uop.mul_sel == MUL_HI_S) begin
            part_next.adj = (op0[`EXE_XLEN-1] ? op1 : '0) + (op1[`EXE_XLEN-1] ? op0 : '0);
        end
        part_next.sel = uop.mul_sel;
        part_next.rd  = uop.rd;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else if (!hold) begin
            done <= en && uop.rd != '0;
        end
    end

    always_ff @(posedge clk) begin
        if (en && !hold) begin
            part <= part_next;
        end
    end

    // E1 sum of the shifted partial products
    assign full = {part.pp_hh, part.pp_ll}
                + {{HALF{1'b0}}, part.pp_hl, {HALF{1'b0}}}
                + {{HALF{1'b0}}, part.pp_lh, {HALF{1'b0}}};

    assign product = (part.sel == MUL_LO) ? full[`EXE_XLEN-1:0]
                                          : full[2*`EXE_XLEN-1:`EXE_XLEN] - part.adj;
    assign rd      = part.rd;

    // a multiply issued while frozen would be dropped
    no_issue_on_hold: assert property (@(posedge clk) disable iff (!rst_n)
        en |-> !hold)
        else $error("multiply issued while the pipeline is held");

endmodule

`default_nettype wire

//--- design/exe_pipe_pkg.sv
`default_nettype none
`include "exe_config.svh"

package exe_pipe_pkg;

    import exe_uop_pkg::*;

    typedef struct packed {
        logic                    valid;
        logic [`EXE_RADDR_W-1:0] rd;
        logic [`EXE_XLEN-1:0]    data;
    } lane_result_t;

    // 16x16 partial products, hh and ll land on the two result halves
    typedef struct packed {
        logic [`EXE_XLEN-1:0]    pp_hh;
        logic [`EXE_XLEN-1:0]    pp_hl;
        logic [`EXE_XLEN-1:0]    pp_lh;
        logic [`EXE_XLEN-1:0]    pp_ll;
        logic [`EXE_XLEN-1:0]    adj;
        mul_sel_e                sel;
        logic [`EXE_RADDR_W-1:0] rd;
    } mul_part_t;

    typedef struct packed {
        logic                    valid;
        logic                    write;
        logic                    sign_ext;
        mem_width_e              width;
        logic [`EXE_RADDR_W-1:0] rd;
        logic [`EXE_STRB_W-1:0]  strb;
        logic [`EXE_XLEN-1:0]    addr;
        logic [`EXE_XLEN-1:0]    wdata;
    } mem_entry_t;

endpackage

`default_nettype wire

//--- design/exe_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "exe_config.svh"

module exe_stage
    import exe_uop_pkg::*;
    import exe_pipe_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic                    lane0_en,
    input  uop_t                    lane0_uop,
    input  logic [`EXE_XLEN-1:0]    lane0_src0,
    input  logic [`EXE_XLEN-1:0]    lane0_src1,
    input  logic                    lane1_en,
    input  uop_t                    lane1_uop,
    input  logic [`EXE_XLEN-1:0]    lane1_src0,
    input  logic [`EXE_XLEN-1:0]    lane1_src1,
    output logic                    mem_req_valid,
    input  logic                    mem_req_ready,
    output logic                    mem_req_write,
    output logic [`EXE_XLEN-1:0]    mem_req_addr,
    output logic [`EXE_STRB_W-1:0]  mem_req_strb,
    output logic [`EXE_XLEN-1:0]    mem_req_wdata,
    input  logic                    mem_rsp_valid,
    input  logic [`EXE_XLEN-1:0]    mem_rsp_rdata,
    output logic                    wb0_valid,
    output logic [`EXE_RADDR_W-1:0] wb0_rd,
    output logic [`EXE_XLEN-1:0]    wb0_data,
    output logic                    wb1_valid,
    output logic [`EXE_RADDR_W-1:0] wb1_rd,
    output logic [`EXE_XLEN-1:0]    wb1_data
);

    logic                    accept;
    logic                    hazard;
    logic                    lsu_busy;
    logic                    lsu_done;
    logic                    mul_done;
    logic [`EXE_RADDR_W-1:0] mul_rd;
    logic [`EXE_RADDR_W-1:0] lsu_rd;
    logic [`EXE_XLEN-1:0]    mul_product;
    logic [`EXE_XLEN-1:0]    lsu_data;
    logic [`EXE_XLEN-1:0]    l0_op0;
    logic [`EXE_XLEN-1:0]    l0_op1;
    logic [`EXE_XLEN-1:0]    l1_op0;
    logic [`EXE_XLEN-1:0]    l1_op1;
    logic [`EXE_XLEN-1:0]    alu0_result;
    logic [`EXE_XLEN-1:0]    alu1_result;
    lane_result_t            s1_l0;
    lane_result_t            s1_l1;
    lane_result_t            s2_l0;
    lane_result_t            s2_l1;
    lane_result_t            e2_l0_next;
    // E2 was loaded at the last edge, not held
    logic                    wb_fresh;

    exe_bypass_if bus (.clk(clk));

    assign in_ready = !lsu_busy && !hazard;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_l0.valid <= 1'b0;
            s1_l1.valid <= 1'b0;
        end else if (!lsu_busy) begin
            s1_l0 <= '{valid: accept && lane0_en && lane0_uop.unit == UNIT_ALU,
                       rd: lane0_uop.rd, data: alu0_result};
            s1_l1 <= '{valid: accept && lane1_en && lane1_uop.unit == UNIT_ALU,
                       rd: lane1_uop.rd, data: alu1_result};
        end
    end

    // lane 0 units finish in E1 and share one writeback
    always_comb begin
        e2_l0_next = s1_l0;
        if (mul_done) begin
            e2_l0_next = '{valid: 1'b1, rd: mul_rd, data: mul_product};
        end else if (lsu_done) begin
            e2_l0_next = '{valid: 1'b1, rd: lsu_rd, data: lsu_data};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s2_l0.valid <= 1'b0;
            s2_l1.valid <= 1'b0;
            wb_fresh    <= 1'b0;
        end else begin
            wb_fresh <= !lsu_busy;
            if (!lsu_busy) begin
                s2_l0 <= e2_l0_next;
                s2_l1 <= s1_l1;
            end
        end
    end

    assign wb0_valid = s2_l0.valid && wb_fresh;
    assign wb0_rd    = s2_l0.rd;
    assign wb0_data  = s2_l0.data;
    assign wb1_valid = s2_l1.valid && wb_fresh;
    assign wb1_rd    = s2_l1.rd;
    assign wb1_data  = s2_l1.data;

    assign bus.s1_l0      = s1_l0;
    assign bus.s1_l1      = s1_l1;
    assign bus.s2_l0      = s2_l0;
    assign bus.s2_l1      = s2_l1;
    assign bus.pend_valid = mul_done || ((lsu_busy || lsu_done) && lsu_rd != '0);
    assign bus.pend_rd    = mul_done ? mul_rd : lsu_rd;

    exe_bypass bypass_i (
        .lane0_uop  (lane0_uop),
        .lane1_uop  (lane1_uop),
        .lane0_src0 (lane0_src0),
        .lane0_src1 (lane0_src1),
        .lane1_src0 (lane1_src0),
        .lane1_src1 (lane1_src1),
        .lane0_en   (lane0_en),
        .lane1_en   (lane1_en),
        .bus        (bus.bypass),
        .lane0_op0  (l0_op0),
        .lane0_op1  (l0_op1),
        .lane1_op0  (l1_op0),
        .lane1_op1  (l1_op1),
        .hazard     (hazard)
    );

    exe_alu alu0_i (.uop(lane0_uop), .op0(l0_op0), .op1(l0_op1), .result(alu0_result));
    exe_alu alu1_i (.uop(lane1_uop), .op0(l1_op0), .op1(l1_op1), .result(alu1_result));

    exe_mul mul_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (accept && lane0_en && lane0_uop.unit == UNIT_MUL),
        .hold    (lsu_busy),
        .uop     (lane0_uop),
        .op0     (l0_op0),
        .op1     (l0_op1),
        .done    (mul_done),
        .rd      (mul_rd),
        .product (mul_product)
    );

    exe_lsu lsu_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (accept && lane0_en && lane0_uop.unit == UNIT_MEM),
        .uop           (lane0_uop),
        .base          (l0_op0),
        .store_data    (l0_op1),
        .busy          (lsu_busy),
        .done          (lsu_done),
        .rd            (lsu_rd),
        .load_data     (lsu_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_write (mem_req_write),
        .mem_req_addr  (mem_req_addr),
        .mem_req_strb  (mem_req_strb),
        .mem_req_wdata (mem_req_wdata),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_rdata (mem_rsp_rdata)
    );

endmodule

`default_nettype wire

//--- design/exe_uop_pkg.sv
`default_nettype none
`include "exe_config.svh"

package exe_uop_pkg;

    typedef enum logic [1:0] {
        UNIT_NONE,
        UNIT_ALU,
        UNIT_MUL,
        UNIT_MEM
    } unit_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        MUL_LO,
        MUL_HI_S,
        MUL_HI_U
    } mul_sel_e;

    typedef enum logic [1:0] {
        MEM_B,
        MEM_H,
        MEM_W
    } mem_width_e;

    typedef struct packed {
        unit_e                   unit;
        alu_op_e                 alu_op;
        logic                    use_imm;
        mul_sel_e                mul_sel;
        logic                    mem_write;
        mem_width_e              mem_width;
        logic                    sign_ext;
        logic [`EXE_RADDR_W-1:0] rd;
        logic [`EXE_RADDR_W-1:0] rj;
        logic [`EXE_RADDR_W-1:0] rk;
        // lui expects the immediate already shifted into place
        logic [`EXE_XLEN-1:0]    imm;
    } uop_t;

endpackage

`default_nettype wire

//--- exe_stage.f
+incdir+design
design/exe_uop_pkg.sv
design/exe_pipe_pkg.sv
design/exe_bypass_if.sv
design/exe_bypass.sv
design/exe_alu.sv
design/exe_mul.sv
design/exe_lsu.sv
design/exe_stage.sv
tests/exe_stage_tb.sv

//--- tests/exe_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "exe_config.svh"

module exe_stage_tb
    import exe_uop_pkg::*;
();

    localparam logic [31:0] SEED = 32'hc9c25cd1;

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid;
    logic                    in_ready;
    logic                    lane0_en;
    logic                    lane1_en;
    uop_t                    lane0_uop;
    uop_t                    lane1_uop;
    logic [`EXE_XLEN-1:0]    lane0_src0;
    logic [`EXE_XLEN-1:0]    lane0_src1;
    logic [`EXE_XLEN-1:0]    lane1_src0;
    logic [`EXE_XLEN-1:0]    lane1_src1;
    logic                    mem_req_valid;
    logic                    mem_req_ready;
    logic                    mem_req_write;
    logic [`EXE_XLEN-1:0]    mem_req_addr;
    logic [`EXE_STRB_W-1:0]  mem_req_strb;
    logic [`EXE_XLEN-1:0]    mem_req_wdata;
    logic                    mem_rsp_valid;
    logic [`EXE_XLEN-1:0]    mem_rsp_rdata;
    logic                    wb0_valid;
    logic [`EXE_RADDR_W-1:0] wb0_rd;
    logic [`EXE_XLEN-1:0]    wb0_data;
    logic                    wb1_valid;
    logic [`EXE_RADDR_W-1:0] wb1_rd;
    logic [`EXE_XLEN-1:0]    wb1_data;

    // shadow register file fed by wb, reference state in program order
    logic [`EXE_XLEN-1:0] rf [`EXE_NUM_REGS];
    logic [`EXE_XLEN-1:0] arch [`EXE_NUM_REGS];
    logic [`EXE_XLEN-1:0] mem [256];
    logic [`EXE_XLEN-1:0] ref_mem [256];
    logic [36:0]          exp0_q [$];
    logic [36:0]          exp1_q [$];
    logic                 ready_pat [256];
    logic [1:0]           delay_pat [256];
    logic                 req_taken = 1'b0;
    logic                 rsp_pending = 1'b0;
    logic [1:0]           rsp_wait = 2'd0;
    logic [`EXE_XLEN-1:0] taken_data;
    int                   cycles = 0;
    int                   groups = 0;
    int                   checks = 0;
    int                   errors = 0;
    int                   test_base = 0;

    exe_stage exe_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > 40 * groups + 100) begin
            $display("timeout after %0d cycles, the DUT stopped accepting or returning work",
                     cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // memory model: write at acceptance, answer 0 to 3 cycles later
    always @(posedge clk) begin
        req_taken <= 1'b0;
        if (rst_n && mem_req_valid && mem_req_ready) begin
            for (int b = 0; b < `EXE_STRB_W; b++) begin
                if (mem_req_write && mem_req_strb[b]) begin
                    mem[mem_req_addr[9:2]][8*b +: 8] = mem_req_wdata[8*b +: 8];
                end
            end
            taken_data <= mem[mem_req_addr[9:2]];
            req_taken  <= 1'b1;
        end
    end

    always @(negedge clk) begin
        mem_req_ready <= ready_pat[cycles % 256];
        mem_rsp_valid <= 1'b0;
        if (req_taken) begin
            rsp_pending = 1'b1;
            rsp_wait    = delay_pat[cycles % 256];
        end
        if (rsp_pending) begin
            if (rsp_wait == 2'd0) begin
                mem_rsp_valid <= 1'b1;
                mem_rsp_rdata <= taken_data;
                rsp_pending = 1'b0;
            end else begin
                rsp_wait = rsp_wait - 2'd1;
            end
        end
    end

    function automatic logic [31:0] fill_word(input logic [7:0] i);
        return {~i, i ^ 8'h5a, i, i + 8'h3c};
    endfunction

    function automatic int rnd_reg(input int nregs);
        return int'($urandom_range(nregs - 1, 0));
    endfunction

    function automatic uop_t alu_uop(input alu_op_e op, input int rd, input int rj, input int rk,
                                     input logic use_imm, input logic [31:0] imm);
        uop_t u;
        u         = '0;
        u.unit    = UNIT_ALU;
        u.alu_op  = op;
        u.use_imm = use_imm;
        u.rd      = 5'(rd);
        u.rj      = 5'(rj);
        u.rk      = 5'(rk);
        u.imm     = imm;
        return u;
    endfunction

    function automatic uop_t mul_uop(input int sel, input int rd, input int rj, input int rk);
        uop_t u;
        u         = alu_uop(ALU_ADD, rd, rj, rk, 1'b0, 32'h0);
        u.unit    = UNIT_MUL;
        u.mul_sel = mul_sel_e'(2'(sel));
        return u;
    endfunction

    function automatic uop_t mem_uop(input logic write, input int width, input logic sign,
                                     input int rd, input int rj, input int rk, input int imm);
        uop_t u;
        u           = alu_uop(ALU_ADD, rd, rj, rk, 1'b0, 32'(imm));
        u.unit      = UNIT_MEM;
        u.mem_write = write;
        u.mem_width = mem_width_e'(2'(width));
        u.sign_ext  = sign;
        return u;
    endfunction

    function automatic logic writes_rd(input uop_t u);
        return u.unit != UNIT_NONE && u.rd != '0 && !(u.unit == UNIT_MEM && u.mem_write);
    endfunction

    // expected destination value from architectural operands a and b
    function automatic logic [31:0] ref_result(input uop_t u, input logic [31:0] a,
                                               input logic [31:0] b);
        logic [31:0] y;
        logic [31:0] addr;
        logic [31:0] w;
        logic [63:0] p;
        y    = u.use_imm ? u.imm : b;
        addr = a + u.imm;
        w    = ref_mem[addr[9:2]] >> (8 * addr[1:0]);
        p    = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        if (u.mul_sel == MUL_HI_U) begin
            p = {32'b0, a} * {32'b0, b};
        end
        case (u.unit)
            UNIT_MUL: return (u.mul_sel == MUL_LO) ? p[31:0] : p[63:32];
            UNIT_MEM: begin
                if (u.mem_width == MEM_B) return {{24{u.sign_ext & w[7]}}, w[7:0]};
                if (u.mem_width == MEM_H) return {{16{u.sign_ext & w[15]}}, w[15:0]};
                return w;
            end
            UNIT_ALU: begin
                case (u.alu_op)
                    ALU_ADD:  return a + y;
                    ALU_SUB:  return a - y;
                    ALU_SLT:  return {31'b0, $signed(a) < $signed(y)};
                    ALU_SLTU: return {31'b0, a < y};
                    ALU_AND:  return a & y;
                    ALU_OR:   return a | y;
                    ALU_XOR:  return a ^ y;
                    ALU_NOR:  return ~(a | y);
                    ALU_SLL:  return a << y[4:0];
                    ALU_SRL:  return a >> y[4:0];
                    ALU_SRA:  return $signed(a) >>> y[4:0];
                    default:  return u.imm;
                endcase
            end
            default: return '0;
        endcase
    endfunction

    task automatic store_ref(input uop_t u, input logic [31:0] a, input logic [31:0] b);
        logic [31:0] addr;
        addr = a + u.imm;
        case (u.mem_width)
            MEM_B:   ref_mem[addr[9:2]][8*addr[1:0] +: 8] = b[7:0];
            MEM_H:   ref_mem[addr[9:2]][16*addr[1] +: 16] = b[15:0];
            default: ref_mem[addr[9:2]] = b;
        endcase
    endtask

    task automatic issue(input logic en0, input uop_t u0, input logic en1, input uop_t u1);
        logic [31:0] v0;
        logic [31:0] v1;
        logic        accepted;
        v0 = ref_result(u0, arch[u0.rj], arch[u0.rk]);
        v1 = ref_result(u1, arch[u1.rj], arch[u1.rk]);
        if (en0 && u0.unit == UNIT_MEM && u0.mem_write) begin
            store_ref(u0, arch[u0.rj], arch[u0.rk]);
        end
        if (en0 && writes_rd(u0)) begin
            exp0_q.push_back({u0.rd, v0});
            arch[u0.rd] = v0;
        end
        if (en1 && writes_rd(u1)) begin
            exp1_q.push_back({u1.rd, v1});
            arch[u1.rd] = v1;
        end
        groups++;
        @(negedge clk);
        in_valid  = 1'b1;
        lane0_en  = en0;
        lane0_uop = u0;
        lane1_en  = en1;
        lane1_uop = u1;
        accepted  = 1'b0;
        while (!accepted) begin
            // register file reads follow retiring results while the group waits
            lane0_src0 = rf[u0.rj];
            lane0_src1 = rf[u0.rk];
            lane1_src0 = rf[u1.rj];
            lane1_src1 = rf[u1.rk];
            @(posedge clk);
            accepted = in_ready;
            if (!accepted) begin
                @(negedge clk);
            end
        end
    endtask

    task automatic check_wb(input int lane, input logic [4:0] rd, input logic [31:0] data);
        logic [36:0] exp;
        if (lane == 0 ? exp0_q.size() == 0 : exp1_q.size() == 0) begin
            $display("lane %0d wrote r%0d at %0t although no result was expected",
                     lane, rd, $time);
            errors++;
        end else begin
            exp = (lane == 0) ? exp0_q.pop_front() : exp1_q.pop_front();
            checks++;
            if (exp != {rd, data}) begin
                $display("[FAIL] %0t lane %0d wrote r%0d=%h, expected r%0d=%h",
                         $time, lane, rd, data, exp[36:32], exp[31:0]);
                errors++;
            end
        end
        rf[rd] = data;
    endtask

    // lane 0 first, so lane 1 wins a shared destination
    always @(posedge clk) begin
        if (rst_n && wb0_valid && wb0_rd != '0) begin
            check_wb(0, wb0_rd, wb0_data);
        end
        if (rst_n && wb1_valid && wb1_rd != '0) begin
            check_wb(1, wb1_rd, wb1_data);
        end
    end

    task automatic random_alu(input int n, input int nregs);
        uop_t u0;
        uop_t u1;
        repeat (n) begin
            u0 = alu_uop(alu_op_e'(4'($urandom_range(11, 0))), rnd_reg(nregs), rnd_reg(nregs),
                         rnd_reg(nregs), 1'($urandom_range(1, 0)), $urandom);
            u1 = alu_uop(alu_op_e'(4'($urandom_range(11, 0))), rnd_reg(nregs), rnd_reg(nregs),
                         rnd_reg(nregs), 1'($urandom_range(1, 0)), $urandom);
            // no lane 1 source may read lane 0's destination
            if (u0.rd != '0 && u1.rj == u0.rd) begin
                u1.rj = '0;
            end
            if (u0.rd != '0 && u1.rk == u0.rd) begin
                u1.rk = '0;
            end
            issue(1'b1, u0, 1'b1, u1);
        end
    endtask

    task automatic end_test(input string name);
        @(negedge clk);
        in_valid = 1'b0;
        lane0_en = 1'b0;
        lane1_en = 1'b0;
        while (exp0_q.size() != 0 || exp1_q.size() != 0 || !in_ready) begin
            @(negedge clk);
        end
        $display("test %-10s %s", name, (errors == test_base) ? "ok" : "had errors");
        test_base = errors;
    endtask

    initial begin
        int n;
        void'($urandom(SEED));
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        lane0_en      = 1'b0;
        lane1_en      = 1'b0;
        lane0_uop     = '0;
        lane1_uop     = '0;
        lane0_src0    = '0;
        lane0_src1    = '0;
        lane1_src0    = '0;
        lane1_src1    = '0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_rdata = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i]       = fill_word(8'(i));
            ref_mem[i]   = fill_word(8'(i));
            ready_pat[i] = 1'($urandom_range(1, 0));
            delay_pat[i] = 2'($urandom_range(3, 0));
        end
        for (int i = 0; i < `EXE_NUM_REGS; i++) begin
            rf[i]   = (i == 0) ? '0 : $urandom;
            arch[i] = rf[i];
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        checks++;
        if (wb0_valid || wb1_valid || mem_req_valid || !in_ready) begin
            $display("[FAIL] %0t outputs not idle after reset", $time);
            errors++;
        end
        end_test("reset");

        random_alu(60, 32);
        end_test("alu");

        // dense register use gives distance one and two chains
        random_alu(80, 4);
        issue(1'b1, alu_uop(ALU_ADD, 5, 0, 0, 1'b1, 32'h1111),
              1'b1, alu_uop(ALU_ADD, 5, 0, 0, 1'b1, 32'h2222));
        issue(1'b1, alu_uop(ALU_OR, 6, 5, 0, 1'b0, 32'h0),
              1'b1, alu_uop(ALU_XOR, 7, 5, 5, 1'b1, 32'h0f0f));
        issue(1'b1, alu_uop(ALU_ADD, 8, 5, 6, 1'b0, 32'h0),
              1'b1, alu_uop(ALU_SUB, 9, 7, 5, 1'b0, 32'h0));
        end_test("forwarding");

        issue(1'b1, alu_uop(ALU_LUI, 1, 0, 0, 1'b1, 32'h8000_0000),
              1'b1, alu_uop(ALU_LUI, 2, 0, 0, 1'b1, 32'h7fff_ffff));
        issue(1'b1, alu_uop(ALU_LUI, 3, 0, 0, 1'b1, 32'hffff_ffff),
              1'b1, alu_uop(ALU_LUI, 4, 0, 0, 1'b1, 32'h0000_0003));
        for (int s = 0; s < 3; s++) begin
            for (int i = 1; i <= 4; i++) begin
                for (int j = 1; j <= 4; j++) begin
                    issue(1'b1, mul_uop(s, 10, i, j), 1'b1, alu_uop(ALU_ADD, 11, i, j, 1'b0, 0));
                    // consumer right behind the multiply has to stall
                    issue(1'b1, alu_uop(ALU_ADD, 12, 10, 0, 1'b1, 32'h1),
                          1'b1, alu_uop(ALU_XOR, 13, 10, 11, 1'b0, 32'h0));
                end
            end
        end
        end_test("multiply");

        issue(1'b1, alu_uop(ALU_LUI, 20, 0, 0, 1'b1, 32'h100), 1'b0, '0);
        repeat (24) begin
            n = int'($urandom_range(2, 0));
            issue(1'b1, mem_uop(1'b1, n, 1'b0, 0, 20, 21, int'($urandom_range(31, 0)) & -(1 << n)),
                  1'b1, alu_uop(ALU_LUI, 21, 0, 0, 1'b1, $urandom));
        end
        n = 0;
        for (int w = 0; w < 3; w++) begin
            for (int a = 0; a < 32; a += 1 << w) begin
                for (int s = 0; s < 2; s++) begin
                    // lane 1 uses the previous load, alternating r22 and r24
                    issue(1'b1, mem_uop(1'b0, w, 1'(s), 22 + 2 * (n % 2), 20, 0, a),
                          1'b1, alu_uop(ALU_ADD, 23, 24 - 2 * (n % 2), 0, 1'b1, 32'h0));
                    n++;
                end
            end
        end
        end_test("load_store");

        $display("checks %0d, errors %0d, groups %0d", checks, errors, groups);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
